//--- camera_display_top.f
hdl/sensor_pkg.sv
hdl/video_pkg.sv
hdl/sensor_power_seq.sv
hdl/status_leds.sv
hdl/video_timing_gen.sv
hdl/pixel_formatter.sv
hdl/camera_display_top.sv
verif/tb_clock_gen.sv
verif/camera_display_assert.sv
verif/camera_display_tb.sv

//--- hdl/camera_display_top.sv
`timescale 1ns/1ps

module camera_display_top #(
    parameter int          RESET_HOLD_CYCLES   = sensor_pkg::DEF_RESET_HOLD_CYCLES,
    parameter int          CONFIG_DELAY_CYCLES = sensor_pkg::DEF_CONFIG_DELAY_CYCLES,
    parameter logic [15:0] H_ACTIVE            = video_pkg::DEF_H_ACTIVE,
    parameter logic [15:0] H_FP                = video_pkg::DEF_H_FP,
    parameter logic [15:0] H_SYNC              = video_pkg::DEF_H_SYNC,
    parameter logic [15:0] H_BP                = video_pkg::DEF_H_BP,
    parameter logic [15:0] V_ACTIVE            = video_pkg::DEF_V_ACTIVE,
    parameter logic [15:0] V_FP                = video_pkg::DEF_V_FP,
    parameter logic [15:0] V_SYNC              = video_pkg::DEF_V_SYNC,
    parameter logic [15:0] V_BP                = video_pkg::DEF_V_BP
) (
    input  logic                               clk,
    input  logic                               rst_n,
    input  logic                               cmos_vsync,
    input  logic                               mem_calib_done,
    input  logic                               pll_lock,
    input  video_pkg::rgb565_t                 pixel_data,   // from frame buffer reader
    output logic                               cmos_rst_n,
    output logic                               cmos_pwdn,
    output logic                               config_start,
    output logic [sensor_pkg::LED_COUNT-1:0]   state_led,
    output logic [video_pkg::COORD_BITS-1:0]   pixel_x,      // read address for frame buffer
    output logic [video_pkg::COORD_BITS-1:0]   pixel_y,
    output video_pkg::color8_t                 rgb_r,
    output video_pkg::color8_t                 rgb_g,
    output video_pkg::color8_t                 rgb_b,
    output logic                               rgb_hs,
    output logic                               rgb_vs,
    output logic                               rgb_de
);

    logic timing_hs;
    logic timing_vs;
    logic timing_de;

    sensor_power_seq #(
        .RESET_HOLD_CYCLES   (RESET_HOLD_CYCLES),
        .CONFIG_DELAY_CYCLES (CONFIG_DELAY_CYCLES)
    ) sensor_power_seq_inst (
        .clk          (clk),
        .rst_n        (rst_n),
        .cmos_rst_n   (cmos_rst_n),
        .cmos_pwdn    (cmos_pwdn),
        .sensor_ready (config_start)  // also lights the ready led
    );

    status_leds status_leds_inst (
        .clk            (clk),
        .rst_n          (rst_n),
        .cmos_vsync     (cmos_vsync),
        .mem_calib_done (mem_calib_done),
        .pll_lock       (pll_lock),
        .sensor_ready   (config_start),
        .state_led      (state_led)
    );

    video_timing_gen #(
        .H_ACTIVE (H_ACTIVE),
        .H_FP     (H_FP),
        .H_SYNC   (H_SYNC),
        .H_BP     (H_BP),
        .V_ACTIVE (V_ACTIVE),
        .V_FP     (V_FP),
        .V_SYNC   (V_SYNC),
        .V_BP     (V_BP)
    ) video_timing_gen_inst (
        .clk      (clk),
        .rst_n    (rst_n),
        .hs       (timing_hs),
        .vs       (timing_vs),
        .de       (timing_de),
        .active_x (pixel_x),
        .active_y (pixel_y)
    );

    pixel_formatter pixel_formatter_inst (
        .clk        (clk),
        .rst_n      (rst_n),
        .hs         (timing_hs),
        .vs         (timing_vs),
        .de         (timing_de),
        .pixel_data (pixel_data),
        .rgb_r      (rgb_r),
        .rgb_g      (rgb_g),
        .rgb_b      (rgb_b),
        .rgb_hs     (rgb_hs),
        .rgb_vs     (rgb_vs),
        .rgb_de     (rgb_de)
    );

endmodule

//--- hdl/pixel_formatter.sv
`timescale 1ns/1ps

module pixel_formatter (
    input  logic               clk,
    input  logic               rst_n,
    input  logic               hs,
    input  logic               vs,
    input  logic               de,
    input  video_pkg::rgb565_t pixel_data,
    output video_pkg::color8_t rgb_r,
    output video_pkg::color8_t rgb_g,
    output video_pkg::color8_t rgb_b,
    output logic               rgb_hs,
    output logic               rgb_vs,
    output logic               rgb_de
);
    import video_pkg::*;

    localparam int RED_LSB   = GREEN_BITS + BLUE_BITS;
    localparam int GREEN_LSB = BLUE_BITS;

    color8_t red_exp;
    color8_t green_exp;
    color8_t blue_exp;

    // zero fill the low bits of each channel
    assign red_exp   = {pixel_data[RED_LSB +: RED_BITS], {(CHANNEL_BITS-RED_BITS){1'b0}}};
    assign green_exp = {pixel_data[GREEN_LSB +: GREEN_BITS], {(CHANNEL_BITS-GREEN_BITS){1'b0}}};
    assign blue_exp  = {pixel_data[0 +: BLUE_BITS], {(CHANNEL_BITS-BLUE_BITS){1'b0}}};

    always_ff @(posedge clk or negedge rst_n)
    begin
        if (!rst_n)
        begin
            rgb_r  <= '0;
            rgb_g  <= '0;
            rgb_b  <= '0;
            rgb_hs <= 1'b0;
            rgb_vs <= 1'b0;
            rgb_de <= 1'b0;
        end
        else
        begin
            rgb_r  <= de ? red_exp : '0;  // black outside active area
            rgb_g  <= de ? green_exp : '0;
            rgb_b  <= de ? blue_exp : '0;
            rgb_hs <= hs;  // same stage as colours
            rgb_vs <= vs;
            rgb_de <= de;
        end
    end

endmodule

//--- hdl/sensor_pkg.sv
package sensor_pkg;

    // sequencing defaults, in clk cycles
    localparam int DEF_RESET_HOLD_CYCLES   = 100_000;     // sensor held in reset
    localparam int DEF_CONFIG_DELAY_CYCLES = 50_000_000;  // register setup may start

    localparam int FRAME_CNT_BITS = 5;  // msb drives the blink led
    localparam int LED_COUNT      = 4;

    typedef enum logic [1:0] {
        ST_HOLD_RESET,   // cmos_rst_n low
        ST_WAIT_CONFIG,  // out of reset, not yet configured
        ST_READY         // configuration may run
    } power_state_t;

    // bit positions inside state_led
    typedef enum logic [1:0] {
        LED_MEM_CALIB    = 2'd0,
        LED_PLL_LOCK     = 2'd1,
        LED_SENSOR_READY = 2'd2,
        LED_FRAME_BLINK  = 2'd3
    } led_index_t;

endpackage

//--- hdl/sensor_power_seq.sv
`timescale 1ns/1ps

module sensor_power_seq #(
    parameter int RESET_HOLD_CYCLES   = sensor_pkg::DEF_RESET_HOLD_CYCLES,
    parameter int CONFIG_DELAY_CYCLES = sensor_pkg::DEF_CONFIG_DELAY_CYCLES
) (
    input  logic clk,
    input  logic rst_n,
    output logic cmos_rst_n,
    output logic cmos_pwdn,
    output logic sensor_ready
);
    import sensor_pkg::*;

    localparam logic [31:0] HOLD_COUNT   = RESET_HOLD_CYCLES;
    localparam logic [31:0] CONFIG_COUNT = CONFIG_DELAY_CYCLES;

    power_state_t state;
    power_state_t state_next;
    logic [31:0]  delay_cnt;

    assign cmos_pwdn = 1'b0;  // sensor never powered down

    always_comb
    begin
        state_next = state;
        case (state)
            ST_HOLD_RESET:
                if (delay_cnt == HOLD_COUNT)
                    state_next = ST_WAIT_CONFIG;
            ST_WAIT_CONFIG:
                if (delay_cnt == CONFIG_COUNT)
                    state_next = ST_READY;
            ST_READY:
                state_next = ST_READY;  // held until next reset
            default:
                state_next = ST_HOLD_RESET;
        endcase
    end

    // outputs decode the next state so they change on the same edge as state
    always_ff @(posedge clk or negedge rst_n)
    begin
        if (!rst_n)
        begin
            state        <= ST_HOLD_RESET;
            delay_cnt    <= '0;
            cmos_rst_n   <= 1'b0;
            sensor_ready <= 1'b0;
        end
        else
        begin
            state        <= state_next;
            cmos_rst_n   <= (state_next != ST_HOLD_RESET);
            sensor_ready <= (state_next == ST_READY);
            if (state_next != ST_READY)
                delay_cnt <= delay_cnt + 32'd1;  // frozen once ready
        end
    end

endmodule

//--- hdl/status_leds.sv
`timescale 1ns/1ps

module status_leds (
    input  logic                           clk,
    input  logic                           rst_n,
    input  logic                           cmos_vsync,
    input  logic                           mem_calib_done,
    input  logic                           pll_lock,
    input  logic                           sensor_ready,
    output logic [sensor_pkg::LED_COUNT-1:0] state_led
);
    import sensor_pkg::*;

    logic                      vsync_meta;
    logic                      vsync_sync;
    logic                      vsync_prev;
    logic                      vsync_rise;
    logic [FRAME_CNT_BITS-1:0] frame_cnt;

    assign vsync_rise = vsync_sync & ~vsync_prev;

    always_ff @(posedge clk or negedge rst_n)
    begin
        if (!rst_n)
        begin
            vsync_meta <= 1'b0;
            vsync_sync <= 1'b0;
            vsync_prev <= 1'b0;
            frame_cnt  <= '0;
        end
        else
        begin
            vsync_meta <= cmos_vsync;  // sensor vsync is asynchronous
            vsync_sync <= vsync_meta;
            vsync_prev <= vsync_sync;
            if (vsync_rise)
                frame_cnt <= frame_cnt + 1'b1;
        end
    end

    // leds are active low, all dark in reset
    always_ff @(posedge clk or negedge rst_n)
    begin
        if (!rst_n)
            state_led <= '1;
        else
        begin
            state_led[LED_MEM_CALIB]    <= ~mem_calib_done;
            state_led[LED_PLL_LOCK]     <= ~pll_lock;
            state_led[LED_SENSOR_READY] <= ~sensor_ready;
            state_led[LED_FRAME_BLINK]  <= ~frame_cnt[FRAME_CNT_BITS-1];  // toggles every 16 frames
        end
    end

endmodule

//--- hdl/video_pkg.sv
package video_pkg;

    // 1280x720 timing, counts in pixel clocks and lines
    localparam logic [15:0] DEF_H_ACTIVE = 16'd1280;
    localparam logic [15:0] DEF_H_FP     = 16'd110;
    localparam logic [15:0] DEF_H_SYNC   = 16'd40;
    localparam logic [15:0] DEF_H_BP     = 16'd220;

    localparam logic [15:0] DEF_V_ACTIVE = 16'd720;
    localparam logic [15:0] DEF_V_FP     = 16'd5;
    localparam logic [15:0] DEF_V_SYNC   = 16'd5;
    localparam logic [15:0] DEF_V_BP     = 16'd20;

    localparam int COORD_BITS = 12;  // covers 0..4095

    // rgb565 field widths, red in the msbs
    localparam int RED_BITS     = 5;
    localparam int GREEN_BITS   = 6;
    localparam int BLUE_BITS    = 5;
    localparam int CHANNEL_BITS = 8;  // one output colour

    typedef logic [RED_BITS+GREEN_BITS+BLUE_BITS-1:0] rgb565_t;
    typedef logic [CHANNEL_BITS-1:0]                  color8_t;

endpackage

//--- hdl/video_timing_gen.sv
`timescale 1ns/1ps

module video_timing_gen #(
    parameter logic [15:0] H_ACTIVE = video_pkg::DEF_H_ACTIVE,
    parameter logic [15:0] H_FP     = video_pkg::DEF_H_FP,
    parameter logic [15:0] H_SYNC   = video_pkg::DEF_H_SYNC,
    parameter logic [15:0] H_BP     = video_pkg::DEF_H_BP,
    parameter logic [15:0] V_ACTIVE = video_pkg::DEF_V_ACTIVE,
    parameter logic [15:0] V_FP     = video_pkg::DEF_V_FP,
    parameter logic [15:0] V_SYNC   = video_pkg::DEF_V_SYNC,
    parameter logic [15:0] V_BP     = video_pkg::DEF_V_BP
) (
    input  logic                             clk,
    input  logic                             rst_n,
    output logic                             hs,
    output logic                             vs,
    output logic                             de,
    output logic [video_pkg::COORD_BITS-1:0] active_x,
    output logic [video_pkg::COORD_BITS-1:0] active_y
);
    import video_pkg::*;

    localparam logic [15:0] H_TOTAL    = H_ACTIVE + H_FP + H_SYNC + H_BP;
    localparam logic [15:0] V_TOTAL    = V_ACTIVE + V_FP + V_SYNC + V_BP;
    localparam logic [15:0] HS_START   = H_ACTIVE + H_FP;
    localparam logic [15:0] HS_END     = H_ACTIVE + H_FP + H_SYNC;  // first clock after pulse
    localparam logic [15:0] VS_START   = V_ACTIVE + V_FP;
    localparam logic [15:0] VS_END     = V_ACTIVE + V_FP + V_SYNC;

    logic [15:0] h_cnt;
    logic [15:0] v_cnt;
    logic        h_last;
    logic        v_last;

    assign h_last = (h_cnt == H_TOTAL - 16'd1);
    assign v_last = (v_cnt == V_TOTAL - 16'd1);

    // pixel and line counters
    always_ff @(posedge clk or negedge rst_n)
    begin
        if (!rst_n)
        begin
            h_cnt <= '0;
            v_cnt <= '0;
        end
        else if (h_last)
        begin
            h_cnt <= '0;
            v_cnt <= v_last ? 16'd0 : v_cnt + 16'd1;
        end
        else
        begin
            h_cnt <= h_cnt + 16'd1;
        end
    end

    // registered decodes, all one clock behind the counters
    always_ff @(posedge clk or negedge rst_n)
    begin
        if (!rst_n)
        begin
            hs       <= 1'b0;
            vs       <= 1'b0;
            de       <= 1'b0;
            active_x <= '0;
            active_y <= '0;
        end
        else
        begin
            hs       <= (h_cnt >= HS_START) && (h_cnt < HS_END);  // positive polarity
            vs       <= (v_cnt >= VS_START) && (v_cnt < VS_END);  // whole lines
            de       <= (h_cnt < H_ACTIVE) && (v_cnt < V_ACTIVE);
            active_x <= h_cnt[COORD_BITS-1:0];  // meaningful while de
            active_y <= v_cnt[COORD_BITS-1:0];
        end
    end

endmodule

//--- run_sim.sh
#!/bin/sh
# build and run the camera display testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --assert -Wno-fatal \
    --top-module camera_display_tb \
    -f camera_display_top.f \
    -o camera_display_sim
status=$?
if [ $status -ne 0 ]; then
    echo "Verilator build failed with status $status"
    exit $status
fi

./obj_dir/camera_display_sim
status=$?
if [ $status -ne 0 ]; then
    echo "simulation failed with status $status"
    exit $status
fi
exit 0

//--- verif/camera_display_assert.sv
`timescale 1ns/1ps

module camera_display_assert (
    input logic clk,
    input logic rst_n,
    input logic cmos_rst_n,
    input logic cmos_pwdn,
    input logic config_start,
    input logic rgb_hs
);

    property config_after_release;
        @(posedge clk) disable iff (!rst_n)
        config_start |-> cmos_rst_n;
    endproperty

    property pwdn_low;
        @(posedge clk) !cmos_pwdn;
    endproperty

    // pulse of exactly three clocks, checked where it ends
    property hs_width;
        @(posedge clk) disable iff (!rst_n)
        $fell(rgb_hs) |-> $past(rgb_hs, 1) && $past(rgb_hs, 2) && $past(rgb_hs, 3)
                          && !$past(rgb_hs, 4);
    endproperty

    config_order_check: assert property (config_after_release)
    else
        $error("config_start is high while cmos_rst_n is low");

    pwdn_check: assert property (pwdn_low)
    else
        $error("cmos_pwdn went high");

    hs_width_check: assert property (hs_width)
    else
        $error("rgb_hs pulse is not three cycles wide");

endmodule

bind camera_display_top camera_display_assert camera_display_assert_inst (
    .clk          (clk),
    .rst_n        (rst_n),
    .cmos_rst_n   (cmos_rst_n),
    .cmos_pwdn    (cmos_pwdn),
    .config_start (config_start),
    .rgb_hs       (rgb_hs)
);

//--- verif/camera_display_tb.sv
`timescale 1ns/1ps

module camera_display_tb;
    import sensor_pkg::*;
    import video_pkg::*;

    // small timing so a frame is 275 clocks
    localparam int H_ACTIVE     = 16;
    localparam int H_FP         = 2;
    localparam int H_SYNC       = 3;
    localparam int H_BP         = 4;
    localparam int V_ACTIVE     = 6;
    localparam int V_FP         = 1;
    localparam int V_SYNC       = 2;
    localparam int V_BP         = 2;
    localparam int H_TOTAL      = H_ACTIVE + H_FP + H_SYNC + H_BP;
    localparam int V_TOTAL      = V_ACTIVE + V_FP + V_SYNC + V_BP;
    localparam int FRAME_CYCLES = H_TOTAL * V_TOTAL;

    logic                  clk;
    logic                  rst_n;
    logic                  cmos_vsync;
    logic                  mem_calib_done;
    logic                  pll_lock;
    rgb565_t               pixel_data;
    logic                  cmos_rst_n;
    logic                  cmos_pwdn;
    logic                  config_start;
    logic [LED_COUNT-1:0]  state_led;
    logic [COORD_BITS-1:0] pixel_x;
    logic [COORD_BITS-1:0] pixel_y;
    color8_t               rgb_r;
    color8_t               rgb_g;
    color8_t               rgb_b;
    logic                  rgb_hs;
    logic                  rgb_vs;
    logic                  rgb_de;
    logic                  fail_reported;
    logic                  all_passed;

    tb_clock_gen #(.PERIOD(40.0)) tb_clock_gen_inst (.clk(clk));

    camera_display_top #(
        .RESET_HOLD_CYCLES   (20),
        .CONFIG_DELAY_CYCLES (60),
        .H_ACTIVE (H_ACTIVE),
        .H_FP     (H_FP),
        .H_SYNC   (H_SYNC),
        .H_BP     (H_BP),
        .V_ACTIVE (V_ACTIVE),
        .V_FP     (V_FP),
        .V_SYNC   (V_SYNC),
        .V_BP     (V_BP)
    ) camera_display_top_inst (.*);

    task automatic stop_run(input string line);
    begin
        fail_reported = 1'b1;
        $display("%s", line);
        $display("Finished with errors");
        $fatal(1, "stopped at the first error");
    end
    endtask

    task automatic compare_logic(input string test, input logic expected, input logic actual);
    begin
        if (actual !== expected)
            stop_run($sformatf("Fail %s expected %0b actual %0b", test, expected, actual));
    end
    endtask

    task automatic compare_led(input string test, input logic [LED_COUNT-1:0] expected,
                               input logic [LED_COUNT-1:0] actual);
    begin
        if (actual !== expected)
            stop_run($sformatf("Fail %s expected %b actual %b", test, expected, actual));
    end
    endtask

    task automatic compare_color(input string test, input color8_t expected,
                                 input color8_t actual);
    begin
        if (actual !== expected)
            stop_run($sformatf("Fail %s expected %h actual %h", test, expected, actual));
    end
    endtask

    task automatic compare_coord(input string test, input logic [COORD_BITS-1:0] expected,
                                 input logic [COORD_BITS-1:0] actual);
    begin
        if (actual !== expected)
            stop_run($sformatf("Fail %s expected %0d actual %0d", test, expected, actual));
    end
    endtask

    task automatic compare_count(input string test, input int expected, input int actual);
    begin
        if (actual != expected)
            stop_run($sformatf("Fail %s expected %0d actual %0d", test, expected, actual));
    end
    endtask

    // returns just after an edge, where outputs are settled and inputs get driven
    task automatic next_cycle;
    begin
        @(posedge clk);
        #2;
    end
    endtask

    task automatic apply_reset;
    begin
        rst_n = 1'b0;
        repeat (16) @(posedge clk);
        #2;
        rst_n = 1'b1;
    end
    endtask

    task automatic wait_vs_rise;
        int   n;
        logic prev;
    begin
        prev = rgb_vs;
        for (n = 0; n < 2 * FRAME_CYCLES; n++)
        begin
            next_cycle();
            if (rgb_vs && !prev)
                return;
            prev = rgb_vs;
        end
        stop_run("Timeout waiting for a rising edge of rgb_vs");
    end
    endtask

    task automatic wait_led(input led_index_t idx, input logic value, input int limit);
        int n;
    begin
        for (n = 0; n < limit && state_led[idx] !== value; n++)
            next_cycle();
        if (state_led[idx] !== value)
            stop_run($sformatf("state_led[%0d] did not reach %0b within %0d cycles",
                               idx, value, limit));
    end
    endtask

    // active-low view of the current inputs and a given frame count
    function automatic logic [LED_COUNT-1:0] expected_leds(input int frames);
        logic [LED_COUNT-1:0]      leds;
        logic [FRAME_CNT_BITS-1:0] frame_cnt;
    begin
        frame_cnt                = frames[FRAME_CNT_BITS-1:0];
        leds[LED_MEM_CALIB]      = ~mem_calib_done;
        leds[LED_PLL_LOCK]       = ~pll_lock;
        leds[LED_SENSOR_READY]   = 1'b0;  // lit once configuration has started
        leds[LED_FRAME_BLINK]    = ~frame_cnt[FRAME_CNT_BITS-1];
        return leds;
    end
    endfunction

    task automatic test_power_up;
        int n;
        int release_cycle;
    begin
        compare_logic("power_up cmos_rst_n", 1'b0, cmos_rst_n);
        compare_logic("power_up config_start", 1'b0, config_start);
        compare_logic("power_up cmos_pwdn", 1'b0, cmos_pwdn);
        n = 0;
        while (!cmos_rst_n && n < 25)
        begin
            next_cycle();
            n++;
            compare_logic("power_up config_start", 1'b0, config_start);
        end
        if (!cmos_rst_n)
            stop_run("cmos_rst_n did not rise within 25 cycles of reset");
        release_cycle = n;
        while (!config_start && n < 70)
        begin
            next_cycle();
            n++;
        end
        if (!config_start)
            stop_run("config_start did not rise within 70 cycles of reset");
        if (n - release_cycle < 30)
            stop_run($sformatf("config_start rose only %0d cycles after cmos_rst_n",
                               n - release_cycle));
        compare_logic("power_up cmos_rst_n held", 1'b1, cmos_rst_n);
        compare_logic("power_up cmos_pwdn", 1'b0, cmos_pwdn);
    end
    endtask

    task automatic test_geometry;
        int   n;
        int   de_run;
        int   de_lines;
        int   vs_high;
        int   hs_rises;
        int   last_hs_rise;
        logic prev_de;
        logic prev_hs;
    begin
        wait_vs_rise();
        de_run       = 0;
        de_lines     = 0;
        vs_high      = 0;
        hs_rises     = 0;
        last_hs_rise = -1;
        prev_de      = rgb_de;
        prev_hs      = rgb_hs;
        for (n = 0; n < FRAME_CYCLES; n++)
        begin
            if (rgb_vs)
                vs_high++;
            if (rgb_de)
                de_run++;
            else if (prev_de)
            begin
                compare_count("geometry de run", H_ACTIVE, de_run);
                de_lines++;
                de_run = 0;
            end
            if (rgb_hs && !prev_hs)
            begin
                if (last_hs_rise >= 0)
                    compare_count("geometry line length", H_TOTAL, n - last_hs_rise);
                last_hs_rise = n;
                hs_rises++;
            end
            prev_de = rgb_de;
            prev_hs = rgb_hs;
            next_cycle();
        end
        compare_count("geometry active lines", V_ACTIVE, de_lines);
        compare_count("geometry hsync pulses", V_TOTAL, hs_rises);
        compare_count("geometry vsync width", V_SYNC * H_TOTAL, vs_high);
    end
    endtask

    task automatic test_coordinates;
        int                    n;
        int                    exp_x;
        int                    exp_y;
        logic [COORD_BITS-1:0] prev_x;
        logic [COORD_BITS-1:0] prev_y;
    begin
        wait_vs_rise();
        exp_x = 0;
        exp_y = 0;
        for (n = 0; n < FRAME_CYCLES; n++)
        begin
            prev_x = pixel_x;  // generator enable shows on rgb_de one clock later
            prev_y = pixel_y;
            next_cycle();
            if (rgb_de)
            begin
                compare_coord("coordinates x", COORD_BITS'(exp_x), prev_x);
                compare_coord("coordinates y", COORD_BITS'(exp_y), prev_y);
                exp_x++;
                if (exp_x == H_ACTIVE)
                begin
                    exp_x = 0;
                    exp_y++;
                end
            end
        end
        compare_count("coordinates lines", V_ACTIVE, exp_y);
    end
    endtask

    task automatic test_colour_expansion;
        int      n;
        int      checked;
        rgb565_t last_pixel;
    begin
        wait_vs_rise();
        checked = 0;
        for (n = 0; n < FRAME_CYCLES; n++)
        begin
            last_pixel = pixel_data;  // captured by the formatter at the next edge
            next_cycle();
            pixel_data = rgb565_t'($urandom);
            if (rgb_de)
            begin
                compare_color("colour red", {last_pixel[15:11], 3'b000}, rgb_r);
                compare_color("colour green", {last_pixel[10:5], 2'b00}, rgb_g);
                compare_color("colour blue", {last_pixel[4:0], 3'b000}, rgb_b);
                checked++;
            end
        end
        compare_count("colour pixels checked", V_ACTIVE * H_ACTIVE, checked);
    end
    endtask

    task automatic test_blanking;
        int n;
        int blank_cycles;
    begin
        wait_vs_rise();
        blank_cycles = 0;
        for (n = 0; n < FRAME_CYCLES; n++)
        begin
            next_cycle();
            pixel_data = rgb565_t'($urandom);
            if (!rgb_de)
            begin
                compare_color("blanking red", 8'h00, rgb_r);
                compare_color("blanking green", 8'h00, rgb_g);
                compare_color("blanking blue", 8'h00, rgb_b);
                blank_cycles++;
            end
        end
        compare_count("blanking cycles", FRAME_CYCLES - V_ACTIVE * H_ACTIVE, blank_cycles);
    end
    endtask

    task automatic test_indicators;
        int n;
    begin
        mem_calib_done = 1'b1;
        wait_led(LED_MEM_CALIB, 1'b0, 3);
        pll_lock = 1'b1;
        wait_led(LED_PLL_LOCK, 1'b0, 3);
        compare_logic("indicators config_start", 1'b1, config_start);
        compare_led("indicators lit", expected_leds(0), state_led);
        mem_calib_done = 1'b0;
        wait_led(LED_MEM_CALIB, 1'b1, 3);
        compare_led("indicators calib off", expected_leds(0), state_led);
        for (n = 1; n <= 16; n++)
        begin
            cmos_vsync = 1'b1;
            repeat (5) next_cycle();
            cmos_vsync = 1'b0;
            repeat (5) next_cycle();
            if (n < 16)
                compare_logic("indicators blink held", 1'b1, state_led[LED_FRAME_BLINK]);
        end
        wait_led(LED_FRAME_BLINK, 1'b0, 8);
        compare_led("indicators blink", expected_leds(16), state_led);
    end
    endtask

    initial
    begin
        void'($urandom(52610));
        fail_reported  = 1'b0;
        all_passed     = 1'b0;
        rst_n          = 1'b0;
        cmos_vsync     = 1'b0;
        mem_calib_done = 1'b0;
        pll_lock       = 1'b0;
        pixel_data     = '0;
        apply_reset();
        test_power_up();
        test_geometry();
        test_coordinates();
        test_colour_expansion();
        test_blanking();
        test_indicators();
        next_cycle();
        all_passed = 1'b1;
        $display("Finished with no errors");
        $finish;
    end

    final
    begin
        if (!fail_reported && !all_passed)
            $display("Finished with errors");
    end

endmodule

//--- verif/tb_clock_gen.sv
`timescale 1ns/1ps

module tb_clock_gen #(
    parameter realtime PERIOD = 40.0
) (
    output logic clk
);

    initial
    begin
        clk = 1'b0;
        forever
            #(PERIOD / 2.0) clk = ~clk;  // 50 % duty
    end

endmodule
